//--- include/ingress_cfg.svh
`ifndef INGRESS_CFG_SVH
`define INGRESS_CFG_SVH

// datapath widths
`define DW_W        32
`define BUF_ADDR_W  11
`define BUF_OFS_W   13
`define LEN_W       10

// register indices from here up are commands
`define CMD_OFFSET  32'h80

// control registers, dword index into the control window
`define REG_STATUS_ADDR       0
`define REG_BUFFER_READY      1
`define REG_WRITE_A_ADDR      2
`define REG_WRITE_B_ADDR      3
`define REG_READ_A_ADDR       4
`define REG_READ_B_ADDR       5
`define REG_BUFFER_SIZE       6
`define REG_DEV_ADDR          7
`define REG_AUX_BUFFER_READY  8

// commands, counted from CMD_OFFSET
`define CMD_RESET           0
`define CMD_PER_WRITE       1
`define CMD_PER_WRITE_FIFO  2
`define CMD_PER_READ        3
`define CMD_PER_READ_FIFO   4
`define CMD_MEM_WRITE       5
`define CMD_MEM_READ        6
`define CMD_DMA_WRITE       7
`define CMD_DMA_READ        8
`define CMD_PING            9

`endif

//--- hdl/tlp_pkg.sv
package tlp_pkg;

  // fmt field, bits 30:29 of header word 0
  typedef enum logic [1:0] {
    FMT_3DW_NO_DATA = 2'b00,
    FMT_4DW_NO_DATA = 2'b01,
    FMT_3DW_DATA    = 2'b10,
    FMT_4DW_DATA    = 2'b11
  } tlp_fmt_e;

  // where a packet is sent after its header
  typedef enum logic [1:0] {
    MEM_WRITE = 2'd0,
    CPL       = 2'd1,
    CPL_DATA  = 2'd2,
    OTHER     = 2'd3
  } tlp_kind_e;

  // type field, bits 28:24, only the values we route on
  typedef enum logic [4:0] {
    TYPE_MEM    = 5'b00000,
    TYPE_CPL    = 5'b01010,
    TYPE_CPL_LK = 5'b01011
  } tlp_type_e;

endpackage

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

  // unit a command is aimed at
  typedef enum logic [1:0] {
    TGT_NONE       = 2'd0,
    TGT_PERIPHERAL = 2'd1,
    TGT_MEMORY     = 2'd2,
    TGT_DMA        = 2'd3
  } cmd_target_e;

  // transfer direction of a command
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } cmd_op_e;

endpackage

//--- hdl/tlp_if.sv
`timescale 1ns/1ps
`include "ingress_cfg.svh"

interface tlp_if import tlp_pkg::*; ();

  // header fields, valid while hdr_valid pulses and held until the next packet
  logic             hdr_valid;
  tlp_kind_e        kind;
  logic [`DW_W-1:0] addr;
  logic [`LEN_W-1:0] len;
  logic [7:0]       tag;
  logic [6:0]       lower_addr;
  logic [2:0]       status;

  // payload, one dword per beat
  logic             beat_valid;
  logic [`DW_W-1:0] beat_data;
  logic             beat_last;

  modport src (
    output hdr_valid, kind, addr, len, tag, lower_addr, status,
    output beat_valid, beat_data, beat_last
  );

  modport dst (
    input hdr_valid, kind, addr, len, tag, lower_addr, status,
    input beat_valid, beat_data, beat_last
  );

endinterface

//--- hdl/tlp_hdr_parser.sv
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module tlp_hdr_parser import tlp_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_valid,
  input  logic [`DW_W-1:0] i_data,
  input  logic             i_last,
  output logic             o_ready,
  output logic             o_unknown_tlp_stb,
  tlp_if.src               wr_bus,
  tlp_if.src               cpl_bus
);

  typedef enum logic [1:0] {
    ST_HDR,
    ST_DATA,
    ST_DROP
  } state_e;

  state_e            state;
  logic [`DW_W-1:0]  hdr [0:3];
  logic [1:0]        hdr_idx;
  logic              hdr_done;
  logic              hdr_end;
  logic              beat_valid_q;
  logic [`DW_W-1:0]  beat_data_q;
  logic              beat_last_q;
  logic              accept;
  logic              has_data;
  logic              is_4dw;
  tlp_fmt_e          fmt;
  tlp_type_e         hdr_type;
  tlp_kind_e         kind;

  assign accept = i_valid && o_ready;

  // word 0 is stored by the time the index reaches 2
  always_comb begin
    fmt      = tlp_fmt_e'(hdr[0][30:29]);
    hdr_type = tlp_type_e'(hdr[0][28:24]);
    has_data = (fmt == FMT_3DW_DATA) || (fmt == FMT_4DW_DATA);
    is_4dw   = (fmt == FMT_4DW_NO_DATA) || (fmt == FMT_4DW_DATA);
    case (hdr_type)
      TYPE_MEM: begin
        if (has_data) kind = MEM_WRITE;
        else kind = OTHER;
      end
      TYPE_CPL, TYPE_CPL_LK: begin
        if (has_data) kind = CPL_DATA;
        else kind = CPL;
      end
      default: kind = OTHER;
    endcase
  end

  assign hdr_end = (hdr_idx == 2'd3) || ((hdr_idx == 2'd2) && !is_4dw);

  always_ff @(posedge clk) begin
    hdr_done     <= 1'b0;
    beat_valid_q <= 1'b0;
    if (rst) begin
      state   <= ST_HDR;
      hdr_idx <= 2'd0;
      o_ready <= 1'b1;
    end else begin
      // one dead cycle between packets
      o_ready <= !(accept && i_last);
      if (accept) begin
        case (state)
          ST_HDR: begin
            if (hdr_end) begin
              hdr_idx  <= 2'd0;
              hdr_done <= 1'b1;
              if (!i_last) begin
                if (kind == OTHER) state <= ST_DROP;
                else state <= ST_DATA;
              end
            end else if (i_last) begin
              // truncated header, start over
              hdr_idx <= 2'd0;
            end else begin
              hdr_idx <= hdr_idx + 2'd1;
            end
          end
          ST_DATA: begin
            beat_valid_q <= 1'b1;
            if (i_last) state <= ST_HDR;
          end
          default: begin
            if (i_last) state <= ST_HDR;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && state == ST_HDR) hdr[hdr_idx] <= i_data;
    if (accept) begin
      beat_data_q <= i_data;
      beat_last_q <= i_last;
    end
  end

  assign o_unknown_tlp_stb  = hdr_done && (kind == OTHER);
  assign wr_bus.hdr_valid   = hdr_done && (kind == MEM_WRITE);
  assign cpl_bus.hdr_valid  = hdr_done && ((kind == CPL) || (kind == CPL_DATA));
  assign wr_bus.beat_valid  = beat_valid_q && (kind == MEM_WRITE);
  assign cpl_bus.beat_valid = beat_valid_q && (kind != MEM_WRITE);

  // both buses see the same header view, only the strobes are steered
  assign wr_bus.kind        = kind;
  assign wr_bus.addr        = {hdr[2][31:2], 2'b00};
  assign wr_bus.len         = hdr[0][`LEN_W-1:0];
  assign wr_bus.tag         = hdr[2][15:8];
  assign wr_bus.lower_addr  = hdr[2][6:0];
  assign wr_bus.status      = hdr[1][15:13];
  assign wr_bus.beat_data   = beat_data_q;
  assign wr_bus.beat_last   = beat_last_q;
  assign cpl_bus.kind       = kind;
  assign cpl_bus.addr       = {hdr[2][31:2], 2'b00};
  assign cpl_bus.len        = hdr[0][`LEN_W-1:0];
  assign cpl_bus.tag        = hdr[2][15:8];
  assign cpl_bus.lower_addr = hdr[2][6:0];
  assign cpl_bus.status     = hdr[1][15:13];
  assign cpl_bus.beat_data  = beat_data_q;
  assign cpl_bus.beat_last  = beat_last_q;

  // a packet goes to one consumer only
  assert property (@(posedge clk) disable iff (rst)
    !(wr_bus.hdr_valid && cpl_bus.hdr_valid));

  // only completions with data hand payload to the writer
  assert property (@(posedge clk) disable iff (rst)
    cpl_bus.beat_valid |-> (kind == CPL_DATA));

  assert property (@(posedge clk) disable iff (rst)
    (accept && i_last) |=> !o_ready);

endmodule

//--- hdl/ctrl_reg_decoder.sv
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module ctrl_reg_decoder import ctrl_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [`DW_W-1:0] i_control_addr_base,
  tlp_if.dst               wr_bus,
  output logic [`DW_W-1:0] o_write_a_addr,
  output logic [`DW_W-1:0] o_write_b_addr,
  output logic [`DW_W-1:0] o_read_a_addr,
  output logic [`DW_W-1:0] o_read_b_addr,
  output logic [`DW_W-1:0] o_status_addr,
  output logic [`DW_W-1:0] o_buffer_size,
  output logic [`DW_W-1:0] o_dev_addr,
  output logic [`DW_W-1:0] o_ping_value,
  output logic [1:0]       o_update_buf,
  output logic             o_update_buf_stb,
  output logic             o_reg_write_stb,
  output logic             o_cmd_rst_stb,
  output logic             o_cmd_wr_stb,
  output logic             o_cmd_rd_stb,
  output logic             o_cmd_ping_stb,
  output logic             o_cmd_unknown_stb,
  output logic             o_cmd_flg_fifo_stb,
  output logic             o_cmd_flg_sel_per_stb,
  output logic             o_cmd_flg_sel_mem_stb,
  output logic             o_cmd_flg_sel_dma_stb,
  output logic [`DW_W-1:0] o_cmd_data_count,
  output logic [`DW_W-1:0] o_cmd_data_address
);

  logic             first_beat;
  logic [`DW_W-1:0] reg_idx;
  logic [`DW_W-1:0] cmd_idx;
  logic             cmd_en;
  logic             cmd_fifo;
  cmd_target_e      cmd_target;
  cmd_op_e          cmd_op;

  // dword index into the control window
  assign reg_idx = (wr_bus.addr - i_control_addr_base) >> 2;
  assign cmd_en  = (reg_idx >= `CMD_OFFSET);
  assign cmd_idx = reg_idx - `CMD_OFFSET;

  always_comb begin
    case (cmd_idx)
      `CMD_PER_WRITE, `CMD_PER_WRITE_FIFO, `CMD_PER_READ, `CMD_PER_READ_FIFO:
        cmd_target = TGT_PERIPHERAL;
      `CMD_MEM_WRITE, `CMD_MEM_READ: cmd_target = TGT_MEMORY;
      `CMD_DMA_WRITE, `CMD_DMA_READ: cmd_target = TGT_DMA;
      default: cmd_target = TGT_NONE;
    endcase
    case (cmd_idx)
      `CMD_PER_WRITE, `CMD_PER_WRITE_FIFO, `CMD_MEM_WRITE, `CMD_DMA_WRITE:
        cmd_op = OP_WRITE;
      `CMD_PER_READ, `CMD_PER_READ_FIFO, `CMD_MEM_READ, `CMD_DMA_READ:
        cmd_op = OP_READ;
      default: cmd_op = OP_NONE;
    endcase
    cmd_fifo = (cmd_idx == `CMD_PER_WRITE_FIFO) || (cmd_idx == `CMD_PER_READ_FIFO);
  end

  always_ff @(posedge clk) begin
    o_update_buf_stb      <= 1'b0;
    o_reg_write_stb       <= 1'b0;
    o_cmd_rst_stb         <= 1'b0;
    o_cmd_wr_stb          <= 1'b0;
    o_cmd_rd_stb          <= 1'b0;
    o_cmd_ping_stb        <= 1'b0;
    o_cmd_unknown_stb     <= 1'b0;
    o_cmd_flg_fifo_stb    <= 1'b0;
    o_cmd_flg_sel_per_stb <= 1'b0;
    o_cmd_flg_sel_mem_stb <= 1'b0;
    o_cmd_flg_sel_dma_stb <= 1'b0;
    if (rst) begin
      first_beat         <= 1'b0;
      o_write_a_addr     <= '0;
      o_write_b_addr     <= '0;
      o_read_a_addr      <= '0;
      o_read_b_addr      <= '0;
      o_status_addr      <= '0;
      o_buffer_size      <= '0;
      o_dev_addr         <= '0;
      o_ping_value       <= '0;
      o_update_buf       <= 2'b00;
      o_cmd_data_count   <= '0;
      o_cmd_data_address <= '0;
    end else begin
      if (wr_bus.hdr_valid) first_beat <= 1'b1;
      else if (wr_bus.beat_valid) first_beat <= 1'b0;

      // only the first payload dword counts
      if (wr_bus.beat_valid && first_beat) begin
        if (cmd_en) begin
          o_cmd_data_count <= wr_bus.beat_data;
          if (cmd_idx == `CMD_RESET) begin
            o_cmd_rst_stb <= 1'b1;
          end else if (cmd_idx == `CMD_PING) begin
            o_cmd_ping_stb <= 1'b1;
            o_ping_value   <= wr_bus.beat_data;
          end else if (cmd_target == TGT_NONE) begin
            o_cmd_unknown_stb <= 1'b1;
          end else begin
            o_cmd_wr_stb          <= (cmd_op == OP_WRITE);
            o_cmd_rd_stb          <= (cmd_op == OP_READ);
            o_cmd_flg_fifo_stb    <= cmd_fifo;
            o_cmd_flg_sel_per_stb <= (cmd_target == TGT_PERIPHERAL);
            o_cmd_flg_sel_mem_stb <= (cmd_target == TGT_MEMORY);
            o_cmd_flg_sel_dma_stb <= (cmd_target == TGT_DMA);
          end
        end else begin
          o_reg_write_stb <= 1'b1;
          case (reg_idx)
            `REG_STATUS_ADDR:  o_status_addr  <= wr_bus.beat_data;
            `REG_WRITE_A_ADDR: o_write_a_addr <= wr_bus.beat_data;
            `REG_WRITE_B_ADDR: o_write_b_addr <= wr_bus.beat_data;
            `REG_READ_A_ADDR:  o_read_a_addr  <= wr_bus.beat_data;
            `REG_READ_B_ADDR:  o_read_b_addr  <= wr_bus.beat_data;
            `REG_BUFFER_SIZE:  o_buffer_size  <= wr_bus.beat_data;
            `REG_BUFFER_READY, `REG_AUX_BUFFER_READY: begin
              o_update_buf     <= wr_bus.beat_data[1:0];
              o_update_buf_stb <= 1'b1;
            end
            `REG_DEV_ADDR: begin
              o_dev_addr         <= wr_bus.beat_data;
              o_cmd_data_address <= wr_bus.beat_data;
            end
            default: ;
          endcase
        end
      end
    end
  end

  // every targeted command has exactly one direction
  assert property (@(posedge clk) disable iff (rst)
    (o_cmd_flg_sel_per_stb || o_cmd_flg_sel_mem_stb || o_cmd_flg_sel_dma_stb)
      |-> (o_cmd_wr_stb ^ o_cmd_rd_stb));

endmodule

//--- hdl/cpl_buf_writer.sv
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module cpl_buf_writer import tlp_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`BUF_OFS_W-1:0]  i_buf_offset,
  tlp_if.dst                     cpl_bus,
  output logic                   o_buf_we,
  output logic [`BUF_ADDR_W-1:0] o_buf_addr,
  output logic [`DW_W-1:0]       o_buf_data,
  output logic                   o_cplt_pkt_stb,
  output logic [`LEN_W-1:0]      o_cplt_pkt_cnt,
  output logic [7:0]             o_cplt_pkt_tag,
  output logic [6:0]             o_cplt_pkt_lwr_addr,
  output logic [2:0]             o_cplt_sts,
  output logic                   o_unexpected_end_stb
);

  // set while a completion still owes payload
  logic              armed;
  logic [`LEN_W-1:0] beat_cnt;

  always_ff @(posedge clk) begin
    o_buf_we             <= 1'b0;
    o_cplt_pkt_stb       <= 1'b0;
    o_unexpected_end_stb <= 1'b0;
    if (rst) begin
      armed               <= 1'b0;
      beat_cnt            <= '0;
      o_buf_addr          <= '0;
      o_buf_data          <= '0;
      o_cplt_pkt_cnt      <= '0;
      o_cplt_pkt_tag      <= 8'h00;
      o_cplt_pkt_lwr_addr <= 7'h00;
      o_cplt_sts          <= 3'd0;
    end else if (cpl_bus.hdr_valid) begin
      beat_cnt <= '0;
      armed    <= (cpl_bus.kind == CPL_DATA);
      if (cpl_bus.kind == CPL_DATA) begin
        o_cplt_pkt_cnt      <= cpl_bus.len;
        o_cplt_pkt_tag      <= cpl_bus.tag;
        o_cplt_pkt_lwr_addr <= cpl_bus.lower_addr;
      end
      // an error status sticks until the next failing one
      if (cpl_bus.status != 3'd0) o_cplt_sts <= cpl_bus.status;
    end else if (armed && cpl_bus.beat_valid) begin
      o_buf_we   <= 1'b1;
      o_buf_data <= cpl_bus.beat_data;
      beat_cnt   <= beat_cnt + 1'b1;
      if (beat_cnt == '0) o_buf_addr <= i_buf_offset[`BUF_ADDR_W-1:0];
      else o_buf_addr <= o_buf_addr + 1'b1;
      if ((beat_cnt + 1'b1) == o_cplt_pkt_cnt) begin
        o_cplt_pkt_stb <= 1'b1;
        armed          <= 1'b0;
      end else if (cpl_bus.beat_last) begin
        // packet ended short of its length
        o_unexpected_end_stb <= 1'b1;
        armed                <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    (cpl_bus.beat_valid && (beat_cnt == o_cplt_pkt_cnt)) |=> !o_buf_we);

endmodule

//--- hdl/pcie_ingress.sv
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module pcie_ingress (
  input  logic                   clk,
  input  logic                   rst,

  // host to device stream
  input  logic                   i_axi_ingress_valid,
  input  logic [`DW_W-1:0]       i_axi_ingress_data,
  input  logic [3:0]             i_axi_ingress_keep,
  input  logic                   i_axi_ingress_last,
  output logic                   o_axi_ingress_ready,

  // control window
  input  logic [`DW_W-1:0]       i_control_addr_base,
  output logic [`DW_W-1:0]       o_write_a_addr,
  output logic [`DW_W-1:0]       o_write_b_addr,
  output logic [`DW_W-1:0]       o_read_a_addr,
  output logic [`DW_W-1:0]       o_read_b_addr,
  output logic [`DW_W-1:0]       o_status_addr,
  output logic [`DW_W-1:0]       o_buffer_size,
  output logic [`DW_W-1:0]       o_dev_addr,
  output logic [`DW_W-1:0]       o_ping_value,
  output logic [1:0]             o_update_buf,
  output logic                   o_update_buf_stb,
  output logic                   o_reg_write_stb,

  // commands
  output logic                   o_cmd_rst_stb,
  output logic                   o_cmd_wr_stb,
  output logic                   o_cmd_rd_stb,
  output logic                   o_cmd_ping_stb,
  output logic                   o_cmd_unknown_stb,
  output logic                   o_cmd_flg_fifo_stb,
  output logic                   o_cmd_flg_sel_per_stb,
  output logic                   o_cmd_flg_sel_mem_stb,
  output logic                   o_cmd_flg_sel_dma_stb,
  output logic [`DW_W-1:0]       o_cmd_data_count,
  output logic [`DW_W-1:0]       o_cmd_data_address,

  // completions and host buffer
  input  logic [`BUF_OFS_W-1:0]  i_buf_offset,
  output logic                   o_buf_we,
  output logic [`BUF_ADDR_W-1:0] o_buf_addr,
  output logic [`DW_W-1:0]       o_buf_data,
  output logic                   o_cplt_pkt_stb,
  output logic [`LEN_W-1:0]      o_cplt_pkt_cnt,
  output logic [7:0]             o_cplt_pkt_tag,
  output logic [6:0]             o_cplt_pkt_lwr_addr,
  output logic [2:0]             o_cplt_sts,
  output logic                   o_unknown_tlp_stb,
  output logic                   o_unexpected_end_stb
);

  // keep is not decoded, every beat is a full dword
  tlp_if wr_bus ();
  tlp_if cpl_bus ();

  tlp_hdr_parser parser_inst (
    .clk               (clk),
    .rst               (rst),
    .i_valid           (i_axi_ingress_valid),
    .i_data            (i_axi_ingress_data),
    .i_last            (i_axi_ingress_last),
    .o_ready           (o_axi_ingress_ready),
    .o_unknown_tlp_stb (o_unknown_tlp_stb),
    .wr_bus            (wr_bus.src),
    .cpl_bus           (cpl_bus.src)
  );

  // port names match the top level one to one
  ctrl_reg_decoder decoder_inst (
    .wr_bus (wr_bus.dst),
    .*
  );

  cpl_buf_writer writer_inst (
    .cpl_bus (cpl_bus.dst),
    .*
  );

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic o_clk,
  output logic o_rst
);

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // reset held for two rising edges
  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

//--- sim/tb_pcie_ingress.sv
`timescale 1ns/1ps
`include "ingress_cfg.svh"

module tb_pcie_ingress;

  localparam string STIM_FILE = "sim/ingress_stim.txt";
  localparam logic [`DW_W-1:0] CTRL_BASE = 32'h0001_0000;
  localparam logic [`BUF_OFS_W-1:0] BUF_OFFSET = 13'h1040;
  localparam int MAX_EXP = 64;

  logic                   clk;
  logic                   rst;
  logic                   i_axi_ingress_valid;
  logic [`DW_W-1:0]       i_axi_ingress_data;
  logic [3:0]             i_axi_ingress_keep;
  logic                   i_axi_ingress_last;
  logic                   o_axi_ingress_ready;
  logic [`DW_W-1:0]       i_control_addr_base;
  logic [`DW_W-1:0]       o_write_a_addr;
  logic [`DW_W-1:0]       o_write_b_addr;
  logic [`DW_W-1:0]       o_read_a_addr;
  logic [`DW_W-1:0]       o_read_b_addr;
  logic [`DW_W-1:0]       o_status_addr;
  logic [`DW_W-1:0]       o_buffer_size;
  logic [`DW_W-1:0]       o_dev_addr;
  logic [`DW_W-1:0]       o_ping_value;
  logic [1:0]             o_update_buf;
  logic                   o_update_buf_stb;
  logic                   o_reg_write_stb;
  logic                   o_cmd_rst_stb;
  logic                   o_cmd_wr_stb;
  logic                   o_cmd_rd_stb;
  logic                   o_cmd_ping_stb;
  logic                   o_cmd_unknown_stb;
  logic                   o_cmd_flg_fifo_stb;
  logic                   o_cmd_flg_sel_per_stb;
  logic                   o_cmd_flg_sel_mem_stb;
  logic                   o_cmd_flg_sel_dma_stb;
  logic [`DW_W-1:0]       o_cmd_data_count;
  logic [`DW_W-1:0]       o_cmd_data_address;
  logic [`BUF_OFS_W-1:0]  i_buf_offset;
  logic                   o_buf_we;
  logic [`BUF_ADDR_W-1:0] o_buf_addr;
  logic [`DW_W-1:0]       o_buf_data;
  logic                   o_cplt_pkt_stb;
  logic [`LEN_W-1:0]      o_cplt_pkt_cnt;
  logic [7:0]             o_cplt_pkt_tag;
  logic [6:0]             o_cplt_pkt_lwr_addr;
  logic [2:0]             o_cplt_sts;
  logic                   o_unknown_tlp_stb;
  logic                   o_unexpected_end_stb;

  // one bit per strobe, check codes 0x10 and up count its pulses
  logic [14:0] strobes;
  int          strobe_total [0:14];
  int          strobe_base [0:14];
  bit          clear_pending;

  string reg_names [0:14] = '{"write_a_addr", "write_b_addr", "read_a_addr", "read_b_addr",
    "status_addr", "buffer_size", "dev_addr", "ping_value", "update_buf", "cmd_data_count",
    "cmd_data_address", "cplt_pkt_cnt", "cplt_pkt_tag", "cplt_pkt_lwr_addr", "cplt_sts"};
  string strobe_names [0:14] = '{"update_buf_stb", "reg_write_stb", "cmd_rst_stb",
    "cmd_wr_stb", "cmd_rd_stb", "cmd_ping_stb", "cmd_unknown_stb", "cmd_flg_fifo_stb",
    "cmd_flg_sel_per_stb", "cmd_flg_sel_mem_stb", "cmd_flg_sel_dma_stb", "cplt_pkt_stb",
    "unknown_tlp_stb", "unexpected_end_stb", "buf_we"};

  // expected buffer writes, in order
  logic [`BUF_ADDR_W-1:0] exp_addr [0:MAX_EXP-1];
  logic [`DW_W-1:0]       exp_data [0:MAX_EXP-1];
  int                     n_exp;
  int                     rd_idx;
  int                     buf_errors;

  int          checks;
  int          errors;
  int          cycles;
  int          cycle_limit;
  logic [31:0] lfsr;

  assign i_control_addr_base = CTRL_BASE;
  assign i_buf_offset        = BUF_OFFSET;
  assign strobes = {o_buf_we, o_unexpected_end_stb, o_unknown_tlp_stb, o_cplt_pkt_stb,
                    o_cmd_flg_sel_dma_stb, o_cmd_flg_sel_mem_stb, o_cmd_flg_sel_per_stb,
                    o_cmd_flg_fifo_stb, o_cmd_unknown_stb, o_cmd_ping_stb, o_cmd_rd_stb,
                    o_cmd_wr_stb, o_cmd_rst_stb, o_reg_write_stb, o_update_buf_stb};

  clk_gen clk_gen_inst (
    .o_clk (clk),
    .o_rst (rst)
  );

  pcie_ingress pcie_ingress_inst (.*);

  always @(negedge clk) begin
    for (int i = 0; i < 15; i++) begin
      if (!rst && strobes[i]) strobe_total[i] <= strobe_total[i] + 1;
    end
  end

  // buffer port monitor
  always @(negedge clk) begin
    if (!rst && o_buf_we) begin
      if (rd_idx >= n_exp) begin
        $display("buffer write to address %h was not expected", o_buf_addr);
        buf_errors++;
      end else begin
        if (o_buf_addr !== exp_addr[rd_idx]) begin
          $display("MISMATCH buffer_addr_%0d expected %h actual %h",
                   rd_idx, exp_addr[rd_idx], o_buf_addr);
          buf_errors++;
        end
        if (o_buf_data !== exp_data[rd_idx]) begin
          $display("MISMATCH buffer_data_%0d expected %h actual %h",
                   rd_idx, exp_data[rd_idx], o_buf_data);
          buf_errors++;
        end
        rd_idx++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: stream not finished after %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] read_output(input logic [7:0] code);
    logic [3:0] idx;
    idx = code[3:0];
    case (code)
      8'h00: return o_write_a_addr;
      8'h01: return o_write_b_addr;
      8'h02: return o_read_a_addr;
      8'h03: return o_read_b_addr;
      8'h04: return o_status_addr;
      8'h05: return o_buffer_size;
      8'h06: return o_dev_addr;
      8'h07: return o_ping_value;
      8'h08: return {30'd0, o_update_buf};
      8'h09: return o_cmd_data_count;
      8'h0A: return o_cmd_data_address;
      8'h0B: return {22'd0, o_cplt_pkt_cnt};
      8'h0C: return {24'd0, o_cplt_pkt_tag};
      8'h0D: return {25'd0, o_cplt_pkt_lwr_addr};
      8'h0E: return {29'd0, o_cplt_sts};
      default: return strobe_total[idx] - strobe_base[idx];
    endcase
  endfunction

  task automatic pick_idle(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      n = (n << 1) | int'(lfsr[0]);
    end
  endtask

  // leaves the beat on the bus with ready seen, transfer at the next rising edge
  task automatic drive_beat(input logic [`DW_W-1:0] data, input logic last);
    int idle;
    pick_idle(idle);
    repeat (idle) begin
      @(posedge clk);
      i_axi_ingress_valid <= 1'b0;
    end
    @(posedge clk);
    if (clear_pending) begin
      for (int i = 0; i < 15; i++) strobe_base[i] = strobe_total[i];
      clear_pending = 1'b0;
    end
    i_axi_ingress_valid <= 1'b1;
    i_axi_ingress_data  <= data;
    i_axi_ingress_last  <= last;
    @(negedge clk);
    while (!o_axi_ingress_ready) @(negedge clk);
  endtask

  task automatic wait_idle();
    @(posedge clk);
    i_axi_ingress_valid <= 1'b0;
    i_axi_ingress_last  <= 1'b0;
    @(negedge clk);
    while (!o_axi_ingress_ready) @(negedge clk);
    // parser stage, then consumer stage
    repeat (2) @(negedge clk);
  endtask

  task automatic check_output(input logic [7:0] code, input logic [31:0] expected);
    logic [31:0] actual;
    checks++;
    if (code > 8'h1E || code == 8'h0F) begin
      $display("check line names unknown output code %h", code);
      errors++;
    end else begin
      actual = read_output(code);
      if (actual !== expected) begin
        $display("MISMATCH %s expected %h actual %h",
                 code < 8'h10 ? reg_names[code[3:0]] : strobe_names[code[3:0]],
                 expected, actual);
        errors++;
      end
    end
  endtask

  initial begin
    int          fd;
    int          n_beats;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    bit          need_idle;
    i_axi_ingress_valid = 1'b0;
    i_axi_ingress_data  = '0;
    i_axi_ingress_keep  = 4'hF;
    i_axi_ingress_last  = 1'b0;
    lfsr = 32'd74788;

    // count beats first for the timeout
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open stimulus file %s", STIM_FILE);
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) == "B") n_beats++;
      end
      $fclose(fd);
      fd = $fopen(STIM_FILE, "r");
    end
    cycle_limit = n_beats * 6 + 200;

    @(negedge clk);
    while (rst) @(negedge clk);

    while (fd != 0 && $fgets(line, fd) != 0) begin
      kind = line.getc(0);
      if (kind == "B" || kind == "C" || kind == "W") begin
        if ($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b) != 2) begin
          $display("stimulus line could not be parsed");
          errors++;
        end else if (kind == "B") begin
          drive_beat(a, b[0]);
          need_idle = 1'b1;
        end else if (kind == "C") begin
          if (need_idle) begin
            wait_idle();
            need_idle = 1'b0;
          end
          check_output(a[7:0], b);
          clear_pending = 1'b1;
        end else if (n_exp < MAX_EXP) begin
          exp_addr[n_exp] = a[`BUF_ADDR_W-1:0];
          exp_data[n_exp] = b;
          n_exp++;
        end else begin
          $display("too many expected buffer writes in stimulus");
          errors++;
        end
      end
    end
    if (fd != 0) $fclose(fd);
    if (need_idle) wait_idle();
    if (rd_idx != n_exp) begin
      $display("only %0d of %0d expected buffer writes happened", rd_idx, n_exp);
      errors++;
    end

    $display("checks %0d, check errors %0d, buffer writes %0d, buffer errors %0d",
             checks, errors, rd_idx, buf_errors);
    if (errors == 0 && buf_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hdl/tlp_pkg.sv
hdl/ctrl_pkg.sv
hdl/tlp_if.sv
hdl/tlp_hdr_parser.sv
hdl/ctrl_reg_decoder.sv
hdl/cpl_buf_writer.sv
hdl/pcie_ingress.sv
sim/clk_gen.sv
sim/tb_pcie_ingress.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pcie_ingress
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/ingress_stim.txt
# B <dword> <last> | C <output code> <expected> | W <buffer addr> <dword>
# output codes as in read_output of sim/tb_pcie_ingress.sv, 10..1E count strobe pulses
# register writes: status, buffer ready, write a/b, read a/b, buffer size, device addr
B 40000001 0
B 0000000F 0
B 00010000 0
B 51A70000 1
B 40000001 0
B 0000000F 0
B 00010004 0
B 00000002 1
B 40000001 0
B 0000000F 0
B 00010008 0
B 0A0A1000 1
B 40000001 0
B 0000000F 0
B 0001000C 0
B 0B0B2000 1
B 40000001 0
B 0000000F 0
B 00010010 0
B 0C0C3000 1
B 40000001 0
B 0000000F 0
B 00010014 0
B 0D0D4000 1
B 40000001 0
B 0000000F 0
B 00010018 0
B 00000800 1
B 40000001 0
B 0000000F 0
B 0001001C 0
B 00C0FFEE 1
C 04 51A70000
C 08 00000002
C 10 00000001
C 00 0A0A1000
C 01 0B0B2000
C 02 0C0C3000
C 03 0D0D4000
C 05 00000800
C 06 00C0FFEE
C 0A 00C0FFEE
C 11 00000008
# peripheral write fifo command
B 40000001 0
B 0000000F 0
B 00010208 0
B 00000010 1
C 13 00000001
C 17 00000001
C 18 00000001
C 14 00000000
C 11 00000000
C 09 00000010
# memory read command
B 40000001 0
B 0000000F 0
B 00010218 0
B 00000020 1
C 14 00000001
C 19 00000001
C 13 00000000
C 17 00000000
C 09 00000020
# dma write command
B 40000001 0
B 0000000F 0
B 0001021C 0
B 00000030 1
C 13 00000001
C 1A 00000001
C 19 00000000
C 09 00000030
# reset command
B 40000001 0
B 0000000F 0
B 00010200 0
B 00000001 1
C 12 00000001
C 13 00000000
C 09 00000001
# ping command
B 40000001 0
B 0000000F 0
B 00010224 0
B 0000BEEF 1
C 15 00000001
C 07 0000BEEF
# undefined command index
B 40000001 0
B 0000000F 0
B 0001023C 0
B 00000077 1
C 16 00000001
C 13 00000000
C 14 00000000
C 09 00000077
# completion with three data dwords
W 040 A0000001
W 041 A0000002
W 042 A0000003
B 4A000003 0
B 0000000C 0
B 00005A14 0
B A0000001 0
B A0000002 0
B A0000003 1
C 1B 00000001
C 0B 00000003
C 0C 0000005A
C 0D 00000014
C 1E 00000003
C 1D 00000000
# completion without data, status 2
B 0A000000 0
B 00004000 0
B 00007700 1
C 0E 00000002
C 1E 00000000
C 1B 00000000
# unknown type aimed at buffer size, then a good write
B 44000001 0
B 00000000 0
B 00010018 0
B 00000BAD 1
B 40000001 0
B 0000000F 0
B 00010008 0
B 0A0A5555 1
C 1C 00000001
C 05 00000800
C 00 0A0A5555
C 11 00000001
# completion of four dwords that ends after two
W 040 B0000001
W 041 B0000002
B 4A000004 0
B 00000000 0
B 00003300 0
B B0000001 0
B B0000002 1
C 1D 00000001
C 1B 00000000
C 1E 00000002
